// ==== all.f ====
rv_pkg.sv
core_control.sv
instr_decode.sv
reg_file.sv
execute_unit.sv
bus_interface.sv
rv_core.sv
rv_core_assert.sv
tb_rv_core.sv

// ==== bus_interface.sv ====
`timescale 1ns/1ns

module bus_interface (
  input  logic              clock,
  input  logic              reset,
  input  logic              req_start,
  input  rv_pkg::bus_sel_t  bus_sel,
  input  logic              write,
  input  rv_pkg::word_t     pc,
  input  rv_pkg::word_t     data_addr,
  input  rv_pkg::word_t     store_data,
  input  logic              inst_load,
  input  logic              data_load,
  output logic              req_done,
  output logic              resp_done,
  output rv_pkg::word_t     inst,
  output rv_pkg::word_t     load_data,
  output rv_pkg::mem_req_t  mem_req,
  input  logic              mem_ready,
  input  rv_pkg::mem_resp_t mem_resp
);

  logic req_valid;
  logic is_data;

  // a new request wins over the transfer of the current one
  always_ff @(posedge clock) begin
    if (reset) begin
      req_valid <= 1'b0;
    end else if (req_start) begin
      req_valid <= 1'b1;
    end else if (mem_ready) begin
      req_valid <= 1'b0;
    end
  end

  assign is_data = (bus_sel == rv_pkg::bus_data);

  // pc, alu result and rs2 do not move while the core waits on the bus
  always_comb begin
    mem_req.valid = req_valid;
    mem_req.write = is_data & write;
    mem_req.addr  = is_data ? data_addr : pc;
    mem_req.wdata = store_data;
  end

  assign req_done  = req_valid & mem_ready;
  assign resp_done = mem_resp.valid;

  always_ff @(posedge clock) begin
    if (inst_load) begin
      inst <= mem_resp.rdata;
    end
    if (data_load) begin
      load_data <= mem_resp.rdata;
    end
  end

endmodule

// ==== core_control.sv ====
`timescale 1ns/1ns

module core_control (
  input  logic              clock,
  input  logic              reset,
  input  rv_pkg::decode_t   dec,
  input  logic              req_done,
  input  logic              resp_done,
  output logic              req_start,
  output rv_pkg::bus_sel_t  bus_sel,
  output logic              inst_load,
  output logic              data_load,
  output logic              pc_load,
  output logic              reg_write_en
);

  rv_pkg::core_state_t state;
  rv_pkg::core_state_t state_next;
  logic boot;
  logic mem_access;
  logic retire;
  logic write_back;

  // high for the first cycle out of reset, launches the very first fetch
  always_ff @(posedge clock) begin
    boot <= reset;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= rv_pkg::state_fetch;
    end else begin
      state <= state_next;
    end
  end

  assign mem_access = (dec.mem_read | dec.mem_write) & ~dec.illegal;

  // req_start goes out one cycle ahead of the state that owns the request
  always_comb begin
    state_next = state;
    req_start  = 1'b0;
    inst_load  = 1'b0;
    data_load  = 1'b0;
    retire     = 1'b0;
    write_back = 1'b0;
    case (state)
      rv_pkg::state_fetch: begin
        req_start = boot;
        if (req_done) begin
          state_next = rv_pkg::state_wait_inst;
        end
      end
      rv_pkg::state_wait_inst: begin
        if (resp_done) begin
          inst_load  = 1'b1;
          state_next = rv_pkg::state_execute;
        end
      end
      rv_pkg::state_execute: begin
        req_start = 1'b1;
        if (mem_access) begin
          state_next = rv_pkg::state_mem_req;
        end else begin
          retire     = 1'b1;
          write_back = 1'b1;
          state_next = rv_pkg::state_fetch;
        end
      end
      rv_pkg::state_mem_req: begin
        if (req_done) begin
          if (dec.mem_write) begin
            // store done at transfer, next fetch follows directly
            req_start  = 1'b1;
            retire     = 1'b1;
            state_next = rv_pkg::state_fetch;
          end else begin
            state_next = rv_pkg::state_wait_data;
          end
        end
      end
      rv_pkg::state_wait_data: begin
        if (resp_done) begin
          data_load  = 1'b1;
          state_next = rv_pkg::state_writeback;
        end
      end
      rv_pkg::state_writeback: begin
        req_start  = 1'b1;
        retire     = 1'b1;
        write_back = 1'b1;
        state_next = rv_pkg::state_fetch;
      end
      default: begin
        state_next = rv_pkg::state_fetch;
      end
    endcase
  end

  assign bus_sel = (state == rv_pkg::state_mem_req) ? rv_pkg::bus_data : rv_pkg::bus_inst;
  assign pc_load = retire;
  assign reg_write_en = write_back & dec.reg_write & ~dec.illegal;

endmodule

// ==== execute_unit.sv ====
`timescale 1ns/1ns

module execute_unit (
  input  logic            clock,
  input  logic            reset,
  input  rv_pkg::decode_t dec,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   load_data,
  input  logic            pc_load,
  output rv_pkg::word_t   pc,
  output rv_pkg::word_t   alu_result,
  output rv_pkg::word_t   write_data
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t branch_target;
  rv_pkg::word_t next_pc;
  logic [4:0] shamt;
  logic eq;
  logic lt;
  logic ltu;
  logic taken;

  always_comb begin
    case (dec.alu_a_sel)
      rv_pkg::a_pc:   op_a = pc;
      rv_pkg::a_zero: op_a = '0;
      default:        op_a = rs1_data;
    endcase
  end

  assign op_b  = (dec.alu_b_sel == rv_pkg::b_imm) ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_sub:  alu_result = op_a - op_b;
      rv_pkg::alu_sll:  alu_result = op_a << shamt;
      rv_pkg::alu_slt:  alu_result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
      rv_pkg::alu_sltu: alu_result = rv_pkg::word_t'(op_a < op_b);
      rv_pkg::alu_xor:  alu_result = op_a ^ op_b;
      rv_pkg::alu_srl:  alu_result = op_a >> shamt;
      rv_pkg::alu_sra:  alu_result = rv_pkg::word_t'($signed(op_a) >>> shamt);
      rv_pkg::alu_or:   alu_result = op_a | op_b;
      rv_pkg::alu_and:  alu_result = op_a & op_b;
      default:          alu_result = op_a + op_b;
    endcase
  end

  // branch compare straight off the register ports
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (dec.branch)
      rv_pkg::br_jal:  taken = 1'b1;
      rv_pkg::br_beq:  taken = eq;
      rv_pkg::br_bne:  taken = ~eq;
      rv_pkg::br_blt:  taken = lt;
      rv_pkg::br_bge:  taken = ~lt;
      rv_pkg::br_bltu: taken = ltu;
      rv_pkg::br_bgeu: taken = ~ltu;
      default:         taken = 1'b0;
    endcase
  end

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc + dec.imm;

  always_comb begin
    if (dec.branch == rv_pkg::br_jalr) begin
      next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};
    end else if (taken) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_comb begin
    case (dec.wb_sel)
      rv_pkg::wb_load: write_data = load_data;
      rv_pkg::wb_link: write_data = pc_plus4;
      default:         write_data = alu_result;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= rv_pkg::reset_pc;
    end else if (pc_load) begin
      pc <= next_pc;
    end
  end

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode (
  input  rv_pkg::word_t   inst,
  output rv_pkg::decode_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic alt;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;
  rv_pkg::alu_op_t alu_fn;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign alt    = inst[30];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // bit 30 means sub only in register form, sra in both forms
  always_comb begin
    case (funct3)
      rv_pkg::f3_add_sub: alu_fn = (alt && opcode == rv_pkg::opcode_op) ?
                                   rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll:     alu_fn = rv_pkg::alu_sll;
      rv_pkg::f3_slt:     alu_fn = rv_pkg::alu_slt;
      rv_pkg::f3_sltu:    alu_fn = rv_pkg::alu_sltu;
      rv_pkg::f3_xor:     alu_fn = rv_pkg::alu_xor;
      rv_pkg::f3_srl_sra: alu_fn = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:      alu_fn = rv_pkg::alu_or;
      rv_pkg::f3_and:     alu_fn = rv_pkg::alu_and;
      default:            alu_fn = rv_pkg::alu_add;
    endcase
  end

  always_comb begin
    dec = '0;
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];
    dec.rd = inst[11:7];
    dec.imm = imm_i;
    dec.alu_op = rv_pkg::alu_add;
    dec.alu_a_sel = rv_pkg::a_rs1;
    dec.alu_b_sel = rv_pkg::b_imm;
    dec.wb_sel = rv_pkg::wb_alu;
    dec.branch = rv_pkg::br_none;
    case (opcode)
      rv_pkg::opcode_lui: begin
        dec.imm = imm_u;
        dec.alu_a_sel = rv_pkg::a_zero;
        dec.reg_write = 1'b1;
      end
      rv_pkg::opcode_auipc: begin
        dec.imm = imm_u;
        dec.alu_a_sel = rv_pkg::a_pc;
        dec.reg_write = 1'b1;
      end
      rv_pkg::opcode_jal: begin
        dec.imm = imm_j;
        dec.alu_a_sel = rv_pkg::a_pc;
        dec.wb_sel = rv_pkg::wb_link;
        dec.branch = rv_pkg::br_jal;
        dec.reg_write = 1'b1;
      end
      rv_pkg::opcode_jalr: begin
        dec.wb_sel = rv_pkg::wb_link;
        dec.branch = rv_pkg::br_jalr;
        dec.reg_write = 1'b1;
        dec.illegal = (funct3 != rv_pkg::f3_jalr);
      end
      rv_pkg::opcode_branch: begin
        dec.imm = imm_b;
        dec.alu_b_sel = rv_pkg::b_rs2;
        case (funct3)
          rv_pkg::f3_beq:  dec.branch = rv_pkg::br_beq;
          rv_pkg::f3_bne:  dec.branch = rv_pkg::br_bne;
          rv_pkg::f3_blt:  dec.branch = rv_pkg::br_blt;
          rv_pkg::f3_bge:  dec.branch = rv_pkg::br_bge;
          rv_pkg::f3_bltu: dec.branch = rv_pkg::br_bltu;
          rv_pkg::f3_bgeu: dec.branch = rv_pkg::br_bgeu;
          default:         dec.illegal = 1'b1;
        endcase
      end
      rv_pkg::opcode_load: begin
        dec.wb_sel = rv_pkg::wb_load;
        dec.reg_write = 1'b1;
        dec.mem_read = 1'b1;
        dec.illegal = (funct3 != rv_pkg::f3_word);
      end
      rv_pkg::opcode_store: begin
        dec.imm = imm_s;
        dec.mem_write = 1'b1;
        dec.illegal = (funct3 != rv_pkg::f3_word);
      end
      rv_pkg::opcode_op_imm: begin
        dec.alu_op = alu_fn;
        dec.reg_write = 1'b1;
      end
      rv_pkg::opcode_op: begin
        dec.alu_op = alu_fn;
        dec.alu_b_sel = rv_pkg::b_rs2;
        dec.reg_write = 1'b1;
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase
    // illegal words fall through to pc + 4
    if (dec.illegal) begin
      dec.branch = rv_pkg::br_none;
    end
  end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic              clock,
  input  logic              reset,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::reg_addr_t rd,
  input  logic              write_en,
  input  rv_pkg::word_t     write_data,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  rv_pkg::word_t regs [2**rv_pkg::reg_addr_width];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**rv_pkg::reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && rd != '0) begin
      regs[rd] <= write_data;
    end
  end

  // x0 is cleared on reset and never written
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert --top-module tb_rv_core -f all.f -o sim_rv_core

# the simulator status is masked by tee, the log decides
./obj_dir/sim_rv_core 2>&1 | tee sim.log

grep -q "TEST PASS" sim.log
echo "simulation passed"

// ==== rv_core.sv ====
`timescale 1ns/1ns

module rv_core (
  input  logic              clock,
  input  logic              reset,
  output rv_pkg::mem_req_t  mem_req,
  input  logic              mem_ready,
  input  rv_pkg::mem_resp_t mem_resp
);

  rv_pkg::decode_t dec;
  rv_pkg::word_t inst;
  rv_pkg::word_t load_data;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t pc;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t write_data;
  rv_pkg::bus_sel_t bus_sel;
  logic req_start;
  logic req_done;
  logic resp_done;
  logic inst_load;
  logic data_load;
  logic pc_load;
  logic reg_write_en;

  core_control core_control_i (
    .clock        (clock),
    .reset        (reset),
    .dec          (dec),
    .req_done     (req_done),
    .resp_done    (resp_done),
    .req_start    (req_start),
    .bus_sel      (bus_sel),
    .inst_load    (inst_load),
    .data_load    (data_load),
    .pc_load      (pc_load),
    .reg_write_en (reg_write_en)
  );

  instr_decode instr_decode_i (
    .inst (inst),
    .dec  (dec)
  );

  reg_file reg_file_i (
    .clock      (clock),
    .reset      (reset),
    .rs1        (dec.rs1),
    .rs2        (dec.rs2),
    .rd         (dec.rd),
    .write_en   (reg_write_en),
    .write_data (write_data),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data)
  );

  execute_unit execute_unit_i (
    .clock      (clock),
    .reset      (reset),
    .dec        (dec),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .load_data  (load_data),
    .pc_load    (pc_load),
    .pc         (pc),
    .alu_result (alu_result),
    .write_data (write_data)
  );

  // data address is the alu sum rs1 + imm
  bus_interface bus_interface_i (
    .clock      (clock),
    .reset      (reset),
    .req_start  (req_start),
    .bus_sel    (bus_sel),
    .write      (dec.mem_write),
    .pc         (pc),
    .data_addr  (alu_result),
    .store_data (rs2_data),
    .inst_load  (inst_load),
    .data_load  (data_load),
    .req_done   (req_done),
    .resp_done  (resp_done),
    .inst       (inst),
    .load_data  (load_data),
    .mem_req    (mem_req),
    .mem_ready  (mem_ready),
    .mem_resp   (mem_resp)
  );

endmodule

// ==== rv_core_assert.sv ====
`timescale 1ns/1ns

module rv_core_assert (
  input logic              clock,
  input logic              reset,
  input rv_pkg::mem_req_t  mem_req,
  input logic              mem_ready,
  input rv_pkg::mem_resp_t mem_resp
);

  logic read_open;

  // one read in flight at most
  always_ff @(posedge clock) begin
    if (reset) begin
      read_open <= 1'b0;
    end else if (mem_req.valid && mem_ready && !mem_req.write) begin
      read_open <= 1'b1;
    end else if (mem_resp.valid) begin
      read_open <= 1'b0;
    end
  end

  request_stable: assert property (@(posedge clock) disable iff (reset)
    (mem_req.valid && !mem_ready) |=> (mem_req.valid && $stable(mem_req.write) &&
      $stable(mem_req.addr) && $stable(mem_req.wdata)))
    else $error("memory request changed while stalled");

  response_expected: assert property (@(posedge clock) disable iff (reset)
    mem_resp.valid |-> read_open)
    else $error("memory response without an outstanding read");

  single_read: assert property (@(posedge clock) disable iff (reset)
    (mem_req.valid && mem_ready && !mem_req.write) |-> !read_open)
    else $error("second read issued before the response to the first");

  idle_in_reset: assert property (@(posedge clock) reset |=> !mem_req.valid)
    else $error("memory request valid during reset");

endmodule

bind rv_core rv_core_assert rv_core_assert_i (
  .clock     (clock),
  .reset     (reset),
  .mem_req   (mem_req),
  .mem_ready (mem_ready),
  .mem_resp  (mem_resp)
);

// ==== rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  localparam word_t reset_pc = 32'h0000_0000;

  // base opcodes, inst[6:0]
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_op     = 7'b0110011;

  // funct3 for alu ops
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 for branches, jalr and word access
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;
  localparam logic [2:0] f3_jalr = 3'b000;
  localparam logic [2:0] f3_word = 3'b010;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [1:0] {a_rs1, a_pc, a_zero} alu_a_sel_t;
  typedef enum logic {b_rs2, b_imm} alu_b_sel_t;
  typedef enum logic [1:0] {wb_alu, wb_load, wb_link} wb_sel_t;

  typedef enum logic [3:0] {
    br_none, br_jal, br_jalr, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
  } branch_t;

  typedef enum logic [2:0] {
    state_fetch, state_wait_inst, state_execute, state_mem_req, state_wait_data,
    state_writeback
  } core_state_t;

  typedef enum logic {bus_inst, bus_data} bus_sel_t;

  typedef struct packed {
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm;
    alu_op_t    alu_op;
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    wb_sel_t    wb_sel;
    branch_t    branch;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       illegal;
  } decode_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
  } mem_resp_t;

endpackage

// ==== tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core;

  localparam rv_pkg::word_t final_addr = 32'h0000_07fc;
  localparam int mem_words = 1024;
  localparam int max_cycles = 20000;

  logic clock;
  logic reset;
  logic mem_ready;
  rv_pkg::mem_req_t mem_req;
  rv_pkg::mem_resp_t mem_resp;

  rv_pkg::word_t mem [mem_words];
  rv_pkg::word_t ref_mem [mem_words];
  rv_pkg::word_t ref_regs [32];
  rv_pkg::word_t exp_addr [$];
  rv_pkg::word_t exp_data [$];
  logic exp_write [$];

  integer seed;
  int prog_len;
  logic done;

  rv_core rv_core_i (
    .clock     (clock),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_resp  (mem_resp)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #50 clock = ~clock;
    end
  end

  function automatic rv_pkg::word_t r_type(int f7, int rs2, int rs1, int f3, int rd, int op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic rv_pkg::word_t i_type(int imm, int rs1, int f3, int rd, int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic rv_pkg::word_t s_type(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_pkg::opcode_store};
  endfunction

  function automatic rv_pkg::word_t b_type(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            rv_pkg::opcode_branch};
  endfunction

  function automatic rv_pkg::word_t u_type(int imm, int rd, int op);
    return {imm[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic rv_pkg::word_t j_type(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::opcode_jal};
  endfunction

  function automatic void put_word(rv_pkg::word_t w);
    mem[prog_len] = w;
    prog_len++;
  endfunction

  function automatic void build_program();
    int op_i;
    int op_r;
    op_i = 32'(rv_pkg::opcode_op_imm);
    op_r = 32'(rv_pkg::opcode_op);
    // background data derived from the full byte address
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = 32'h5a5a_0000 ^ (i * 4);
    end
    prog_len = 0;
    put_word(u_type(32'h12345, 2, 32'(rv_pkg::opcode_lui)));
    put_word(i_type(32'h678, 2, 0, 2, op_i));
    put_word(u_type(1, 3, 32'(rv_pkg::opcode_auipc)));
    put_word(i_type(32'h400, 0, 0, 1, op_i));
    put_word(i_type(-5, 0, 0, 4, op_i));
    put_word(i_type(7, 0, 0, 5, op_i));
    put_word(r_type(0, 5, 4, 0, 6, op_r));
    put_word(r_type(32'h20, 5, 4, 0, 7, op_r));
    put_word(r_type(0, 5, 5, 1, 8, op_r));
    put_word(r_type(0, 5, 4, 2, 9, op_r));
    put_word(r_type(0, 5, 4, 3, 10, op_r));
    put_word(r_type(0, 5, 4, 4, 11, op_r));
    put_word(r_type(0, 5, 4, 5, 12, op_r));
    put_word(r_type(32'h20, 5, 4, 5, 13, op_r));
    put_word(r_type(0, 5, 4, 6, 14, op_r));
    put_word(r_type(0, 5, 4, 7, 15, op_r));
    put_word(i_type(-3, 4, 2, 16, op_i));
    put_word(i_type(-1, 5, 3, 17, op_i));
    put_word(i_type(32'h0f0, 4, 4, 18, op_i));
    put_word(i_type(32'h30f, 5, 6, 19, op_i));
    put_word(i_type(32'h7f3, 4, 7, 20, op_i));
    put_word(i_type(3, 4, 1, 21, op_i));
    put_word(i_type(4, 4, 5, 22, op_i));
    put_word(i_type(32'h404, 4, 5, 23, op_i));
    for (int k = 2; k <= 23; k++) begin
      put_word(s_type((k - 2) * 4, k, 1));
    end
    // unknown opcode with x31 in the rd field
    put_word(32'hffff_ffff);
    put_word(s_type(32'h90, 31, 1));
    put_word(s_type(32'h80, 0, 1));
    put_word(i_type(8, 1, 2, 24, 32'(rv_pkg::opcode_load)));
    put_word(s_type(32'h84, 24, 1));
    put_word(i_type(32'h80, 1, 2, 25, 32'(rv_pkg::opcode_load)));
    put_word(s_type(32'h88, 25, 1));
    // each branch kind taken once and not taken once
    put_word(b_type(8, 5, 5, 0));
    put_word(i_type(1, 26, 0, 26, op_i));
    put_word(b_type(8, 5, 4, 0));
    put_word(i_type(1, 26, 0, 26, op_i));
    put_word(b_type(8, 5, 4, 1));
    put_word(i_type(1, 26, 0, 26, op_i));
    put_word(b_type(8, 5, 5, 1));
    put_word(i_type(1, 26, 0, 26, op_i));
    put_word(b_type(8, 5, 4, 4));
    put_word(i_type(1, 26, 0, 26, op_i));
    put_word(b_type(8, 4, 5, 4));
    put_word(i_type(1, 26, 0, 26, op_i));
    put_word(b_type(8, 4, 5, 5));
    put_word(i_type(1, 26, 0, 26, op_i));
    put_word(b_type(8, 5, 4, 5));
    put_word(i_type(1, 26, 0, 26, op_i));
    put_word(b_type(8, 4, 5, 6));
    put_word(i_type(1, 26, 0, 26, op_i));
    put_word(b_type(8, 5, 4, 6));
    put_word(i_type(1, 26, 0, 26, op_i));
    put_word(b_type(8, 5, 4, 7));
    put_word(i_type(1, 26, 0, 26, op_i));
    put_word(b_type(8, 4, 5, 7));
    put_word(i_type(1, 26, 0, 26, op_i));
    // short backward loop
    put_word(i_type(3, 0, 0, 27, op_i));
    put_word(i_type(-1, 27, 0, 27, op_i));
    put_word(b_type(-4, 0, 27, 1));
    put_word(j_type(8, 28));
    put_word(i_type(100, 26, 0, 26, op_i));
    put_word(u_type(0, 29, 32'(rv_pkg::opcode_auipc)));
    // jalr drops bit 0 of the odd target
    put_word(i_type(13, 29, 0, 30, 32'(rv_pkg::opcode_jalr)));
    put_word(i_type(100, 26, 0, 26, op_i));
    put_word(s_type(32'ha0, 26, 1));
    put_word(s_type(32'ha4, 27, 1));
    put_word(s_type(32'ha8, 28, 1));
    put_word(s_type(32'hac, 29, 1));
    put_word(s_type(32'hb0, 30, 1));
    put_word(s_type(32'h3fc, 0, 1));
  endfunction

  function automatic void note_transfer(logic write, rv_pkg::word_t addr, rv_pkg::word_t data);
    exp_write.push_back(write);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endfunction

  function automatic rv_pkg::word_t alu_reference(logic [2:0] f3, logic alt, logic is_reg,
                                                  rv_pkg::word_t x, rv_pkg::word_t y);
    rv_pkg::word_t res;
    case (f3)
      3'b000: res = (alt && is_reg) ? x - y : x + y;
      3'b001: res = x << y[4:0];
      3'b010: res = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011: res = (x < y) ? 32'd1 : 32'd0;
      3'b100: res = x ^ y;
      3'b101: begin
        if (alt) begin
          res = rv_pkg::word_t'($signed(x) >>> y[4:0]);
        end else begin
          res = x >> y[4:0];
        end
      end
      3'b110: res = x | y;
      default: res = x & y;
    endcase
    return res;
  endfunction

  // instruction set model that fills the expected transfer queues
  function automatic void run_reference();
    rv_pkg::word_t pc;
    rv_pkg::word_t next_pc;
    rv_pkg::word_t inst;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t res;
    rv_pkg::word_t addr;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_j;
    rv_pkg::reg_addr_t rd;
    logic [6:0] op;
    logic [2:0] f3;
    logic wr;
    logic taken;
    logic stop;
    pc = rv_pkg::reset_pc;
    stop = 1'b0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    for (int steps = 0; steps < 5000 && !stop; steps++) begin
      inst = ref_mem[pc[11:2]];
      note_transfer(1'b0, pc, '0);
      op = inst[6:0];
      f3 = inst[14:12];
      rd = inst[11:7];
      a = ref_regs[inst[19:15]];
      b = ref_regs[inst[24:20]];
      imm_i = {{20{inst[31]}}, inst[31:20]};
      imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      next_pc = pc + 4;
      wr = 1'b0;
      res = '0;
      case (op)
        rv_pkg::opcode_lui: begin
          res = {inst[31:12], 12'b0};
          wr = 1'b1;
        end
        rv_pkg::opcode_auipc: begin
          res = pc + {inst[31:12], 12'b0};
          wr = 1'b1;
        end
        rv_pkg::opcode_jal: begin
          res = pc + 4;
          next_pc = pc + imm_j;
          wr = 1'b1;
        end
        rv_pkg::opcode_jalr: begin
          res = pc + 4;
          next_pc = (a + imm_i) & ~32'd1;
          wr = 1'b1;
        end
        rv_pkg::opcode_branch: begin
          case (f3)
            3'b000: taken = (a == b);
            3'b001: taken = (a != b);
            3'b100: taken = ($signed(a) < $signed(b));
            3'b101: taken = ($signed(a) >= $signed(b));
            3'b110: taken = (a < b);
            default: taken = (a >= b);
          endcase
          if (taken) begin
            next_pc = pc + imm_b;
          end
        end
        rv_pkg::opcode_load: begin
          addr = a + imm_i;
          note_transfer(1'b0, addr, '0);
          res = ref_mem[addr[11:2]];
          wr = 1'b1;
        end
        rv_pkg::opcode_store: begin
          addr = a + imm_s;
          note_transfer(1'b1, addr, b);
          ref_mem[addr[11:2]] = b;
          stop = (addr == final_addr);
        end
        rv_pkg::opcode_op_imm: begin
          res = alu_reference(f3, inst[30], 1'b0, a, imm_i);
          wr = 1'b1;
        end
        rv_pkg::opcode_op: begin
          res = alu_reference(f3, inst[30], 1'b1, a, b);
          wr = 1'b1;
        end
        default: begin
          wr = 1'b0;
        end
      endcase
      if (wr && rd != '0) begin
        ref_regs[rd] = res;
      end
      pc = next_pc;
    end
  endfunction

  task automatic stop_on_failure(string what);
    $display("%0t ns: %s", $time, what);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic show_mismatch(string name, rv_pkg::word_t expected, rv_pkg::word_t actual);
    $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    stop_on_failure("bus transfer mismatch");
  endtask

  // memory model and transfer checker run on the falling edge
  initial begin
    int latency;
    logic pending;
    rv_pkg::word_t resp_word;
    rv_pkg::word_t word;
    pending = 1'b0;
    latency = 0;
    resp_word = '0;
    forever begin
      @(negedge clock);
      mem_resp = '0;
      if (pending) begin
        if (latency == 1) begin
          mem_resp.valid = 1'b1;
          mem_resp.rdata = resp_word;
          pending = 1'b0;
        end else begin
          latency--;
        end
      end
      mem_ready = (($random(seed) & 3) != 0);
      if (reset) begin
        assert (mem_req.valid == 1'b0)
          else show_mismatch("mem_req.valid", 32'd0, 32'(mem_req.valid));
      end else if (mem_req.valid && mem_ready && !done) begin
        assert (exp_addr.size() != 0)
          else stop_on_failure("bus transfer with no expected transfer left");
        assert (mem_req.write == exp_write[0])
          else show_mismatch("mem_req.write", 32'(exp_write[0]), 32'(mem_req.write));
        assert (mem_req.addr == exp_addr[0])
          else show_mismatch("mem_req.addr", exp_addr[0], mem_req.addr);
        word = mem_req.addr;
        if (mem_req.write) begin
          assert (mem_req.wdata == exp_data[0])
            else show_mismatch("mem_req.wdata", exp_data[0], mem_req.wdata);
          mem[word[11:2]] = mem_req.wdata;
          done = (mem_req.addr == final_addr);
        end else begin
          resp_word = mem[word[11:2]];
          latency = 1 + ($random(seed) & 3);
          pending = 1'b1;
        end
        void'(exp_write.pop_front());
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  initial begin
    int cycles;
    seed = 32'hb038;
    done = 1'b0;
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_resp = '0;
    build_program();
    for (int i = 0; i < mem_words; i++) begin
      ref_mem[i] = mem[i];
    end
    run_reference();
    repeat (5) @(negedge clock);
    reset = 1'b0;
    cycles = 0;
    while (!done && cycles < max_cycles) begin
      @(negedge clock);
      cycles++;
    end
    if (done) begin
      $display("TEST PASS");
      $finish;
    end else begin
      stop_on_failure("timeout waiting for the final store");
    end
  end

endmodule
